//--- core_defines.svh
/*
 * Core configuration macros
 * Widths, register count, reset address and multiplier depth
 */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and instruction width
`define CORE_XLEN 32

// Register file geometry
`define CORE_REG_ADDR_W 5
`define CORE_REG_COUNT 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// Multiplier pipeline depth
`define CORE_MUL_STAGES 2

`endif

//--- core_pkg.sv
/*
 * Core type package
 * Opcodes, ALU operations, unit selection and the packets
 * passed between issue, execution units and writeback
 */
`include "core_defines.svh"

package core_pkg;

    // Major opcodes handled by decode
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } alu_op_t;

    // Higher value wins writeback
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_t;

    typedef struct packed {
        alu_op_t                     alu_op;
        logic [`CORE_XLEN-1:0]       a;
        logic [`CORE_XLEN-1:0]       b;
        logic [`CORE_REG_ADDR_W-1:0] rd;
    } issue_packet_t;

    typedef struct packed {
        logic                        valid;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]       data;
    } wb_packet_t;

endpackage

//--- exec_unit_if.sv
/*
 * Execution unit link
 * Issue handshake from decode and done/ack writeback
 * handshake towards the arbiter
 */
`include "core_defines.svh"

interface exec_unit_if;

    // Issue side
    logic                    issue_valid;
    logic                    issue_ready;
    core_pkg::issue_packet_t packet;

    // Writeback side
    logic                        done;
    logic [`CORE_REG_ADDR_W-1:0] result_rd;
    logic [`CORE_XLEN-1:0]       result_data;
    logic                        ack;

    modport issue (
        output issue_valid, packet,
        input  issue_ready
    );

    modport unit (
        input  issue_valid, packet, ack,
        output issue_ready, done, result_rd, result_data
    );

    modport wb (
        input  done, result_rd, result_data,
        output ack
    );

endinterface

//--- fetch_unit.sv
/*
 * Instruction fetch
 * Sequential PC driving a Wishbone classic read cycle,
 * with a one-entry buffer towards decode
 */
`include "core_defines.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic                  ibus_cyc,
    output logic                  ibus_stb,
    output logic [`CORE_XLEN-1:0] ibus_adr,
    input  logic [`CORE_XLEN-1:0] ibus_dat_r,
    input  logic                  ibus_ack,
    output logic                  instr_valid,
    output logic [`CORE_XLEN-1:0] instr,
    input  logic                  instr_ready
);

    logic [`CORE_XLEN-1:0] pc;
    logic                  buf_valid;
    logic [`CORE_XLEN-1:0] buf_data;
    logic                  xfer_done;
    logic                  buf_free;

    assign xfer_done = ibus_cyc && ibus_ack;
    // Buffer empty now or drained on this edge
    assign buf_free  = !buf_valid || instr_ready;

    assign ibus_stb    = ibus_cyc;
    assign ibus_adr    = pc;
    assign instr_valid = buf_valid;
    assign instr       = buf_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc        <= `CORE_RESET_PC;
            ibus_cyc  <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (xfer_done) begin
                ibus_cyc <= 1'b0;
                pc       <= pc + 32'd4;
            end else if (!ibus_cyc && buf_free) begin
                ibus_cyc <= 1'b1;
            end

            if (xfer_done) begin
                buf_valid <= 1'b1;
            end else if (instr_ready) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_done) begin
            buf_data <= ibus_dat_r;
        end
    end

    //////////////////////////////////////////////////
    // Request held with a stable address until acked
    assert property (@(posedge clk) disable iff (!rst_n)
        ibus_cyc && !ibus_ack |=> ibus_cyc && $stable(ibus_adr));

endmodule

//--- decode_issue.sv
/*
 * Decode and issue
 * Decodes OP, OP-IMM and MUL, tracks busy registers and
 * dispatches operands to the ALU or the multiplier
 */
`include "core_defines.svh"

module decode_issue (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        instr_valid,
    input  logic [`CORE_XLEN-1:0]       instr,
    output logic                        instr_ready,
    output logic [`CORE_REG_ADDR_W-1:0] rs1_addr,
    output logic [`CORE_REG_ADDR_W-1:0] rs2_addr,
    input  logic [`CORE_XLEN-1:0]       rs1_data,
    input  logic [`CORE_XLEN-1:0]       rs2_data,
    input  core_pkg::wb_packet_t        wb,
    exec_unit_if.issue                  alu_if,
    exec_unit_if.issue                  mul_if
);

    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic                        is_op;
    logic                        is_imm;
    logic                        legal;
    logic                        is_nop;
    logic                        hazard;
    logic                        unit_ready;
    logic                        alu_fire;
    logic                        mul_fire;
    logic [`CORE_XLEN-1:0]       imm;
    logic [`CORE_REG_COUNT-1:0]  busy;
    core_pkg::alu_op_t           alu_op;
    core_pkg::unit_t             unit;
    core_pkg::issue_packet_t     packet;

    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rd       = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign is_op    = (instr[6:0] == core_pkg::OP);
    assign is_imm   = (instr[6:0] == core_pkg::OP_IMM);
    assign imm      = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};

    //////////////////////////////////////////////////
    // Field decode
    always_comb begin
        unit  = core_pkg::UNIT_ALU;
        legal = 1'b0;
        case (funct3)
            3'b000:  alu_op = (is_op && funct7[5]) ? core_pkg::SUB : core_pkg::ADD;
            3'b001:  alu_op = core_pkg::SLL;
            3'b010:  alu_op = core_pkg::SLT;
            3'b011:  alu_op = core_pkg::SLTU;
            3'b100:  alu_op = core_pkg::XOR;
            3'b101:  alu_op = funct7[5] ? core_pkg::SRA : core_pkg::SRL;
            3'b110:  alu_op = core_pkg::OR;
            default: alu_op = core_pkg::AND;
        endcase

        if (is_op) begin
            if (funct7 == 7'b0000001) begin
                // Only MUL of the M extension
                unit  = core_pkg::UNIT_MUL;
                legal = (funct3 == 3'b000);
            end else begin
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
        end else if (is_imm) begin
            if (funct3 == 3'b001) begin
                legal = (funct7 == 7'b0000000);
            end else if (funct3 == 3'b101) begin
                legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            end else begin
                legal = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Hazards and dispatch
    assign is_nop     = !legal || (rd == '0);
    // rs2 field is immediate bits for OP-IMM
    assign hazard     = busy[rs1_addr] || (is_op && busy[rs2_addr]) || busy[rd];
    assign unit_ready = (unit == core_pkg::UNIT_MUL) ? mul_if.issue_ready
                                                     : alu_if.issue_ready;

    assign alu_if.issue_valid = instr_valid && !is_nop && !hazard &&
                                (unit == core_pkg::UNIT_ALU);
    assign mul_if.issue_valid = instr_valid && !is_nop && !hazard &&
                                (unit == core_pkg::UNIT_MUL);
    assign instr_ready        = is_nop || (!hazard && unit_ready);

    assign alu_fire = alu_if.issue_valid && alu_if.issue_ready;
    assign mul_fire = mul_if.issue_valid && mul_if.issue_ready;

    assign packet.alu_op = alu_op;
    assign packet.a      = rs1_data;
    assign packet.b      = is_op ? rs2_data : imm;
    assign packet.rd     = rd;
    assign alu_if.packet = packet;
    assign mul_if.packet = packet;

    // Set and clear never hit the same register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (wb.valid) begin
                busy[wb.rd] <= 1'b0;
            end
            if (alu_fire || mul_fire) begin
                busy[rd] <= 1'b1;
            end
        end
    end

    // Every writeback returns a register reserved at issue
    assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> busy[wb.rd]);

endmodule

//--- register_file.sv
/*
 * Integer register file
 * 32 x 32 bit, two combinational read ports with
 * writeback bypass, one write port, x0 reads zero
 */
`include "core_defines.svh"

module register_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CORE_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`CORE_REG_ADDR_W-1:0] rs2_addr,
    output logic [`CORE_XLEN-1:0]       rs1_data,
    output logic [`CORE_XLEN-1:0]       rs2_data,
    input  core_pkg::wb_packet_t        wb
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

    function automatic logic [`CORE_XLEN-1:0] read_port(
        input logic [`CORE_REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (wb.valid && wb.rd == addr) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Decode drops rd x0, so no unit ever returns it
    assert property (@(posedge clk) disable iff (!rst_n) wb.valid |-> wb.rd != '0);

endmodule

//--- alu_unit.sv
/*
 * Integer ALU
 * Single-cycle RV32I operations, result held until acked
 */
`include "core_defines.svh"

module alu_unit (
    input  logic       clk,
    input  logic       rst_n,
    exec_unit_if.unit  alu_if
);

    localparam int SHAMT_W = $clog2(`CORE_XLEN);

    logic [`CORE_XLEN-1:0] a;
    logic [`CORE_XLEN-1:0] b;
    logic [SHAMT_W-1:0]    shamt;
    logic [`CORE_XLEN-1:0] result;
    logic                  fire;

    assign a     = alu_if.packet.a;
    assign b     = alu_if.packet.b;
    assign shamt = b[SHAMT_W-1:0];
    assign fire  = alu_if.issue_valid && alu_if.issue_ready;

    // Free when empty or leaving this cycle
    assign alu_if.issue_ready = !alu_if.done || alu_if.ack;

    always_comb begin
        case (alu_if.packet.alu_op)
            core_pkg::SUB:  result = a - b;
            core_pkg::SLL:  result = a << shamt;
            core_pkg::SLT:  result = {{(`CORE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            core_pkg::SLTU: result = {{(`CORE_XLEN-1){1'b0}}, a < b};
            core_pkg::XOR:  result = a ^ b;
            core_pkg::SRL:  result = a >> shamt;
            core_pkg::SRA:  result = $unsigned($signed(a) >>> shamt);
            core_pkg::OR:   result = a | b;
            core_pkg::AND:  result = a & b;
            default:        result = a + b;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_if.done <= 1'b0;
        end else if (fire) begin
            alu_if.done <= 1'b1;
        end else if (alu_if.ack) begin
            alu_if.done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            alu_if.result_rd   <= alu_if.packet.rd;
            alu_if.result_data <= result;
        end
    end

endmodule

//--- mul_unit.sv
/*
 * Pipelined multiplier
 * Signed 32 x 32 product, low word kept, whole pipe
 * freezes while the last stage waits for ack
 */
`include "core_defines.svh"

module mul_unit (
    input  logic       clk,
    input  logic       rst_n,
    exec_unit_if.unit  mul_if
);

    localparam int STAGES = `CORE_MUL_STAGES;

    logic [STAGES-1:0]           stage_valid;
    logic [`CORE_REG_ADDR_W-1:0] stage_rd   [STAGES];
    logic [`CORE_XLEN-1:0]       stage_data [STAGES];
    logic signed [2*`CORE_XLEN-1:0] product;
    logic                        stall;
    logic                        fire;

    assign product = $signed(mul_if.packet.a) * $signed(mul_if.packet.b);

    // Back-pressure from an unacked result
    assign stall = stage_valid[STAGES-1] && !mul_if.ack;
    assign fire  = mul_if.issue_valid && mul_if.issue_ready;

    assign mul_if.issue_ready = !stall;
    assign mul_if.done        = stage_valid[STAGES-1];
    assign mul_if.result_rd   = stage_rd[STAGES-1];
    assign mul_if.result_data = stage_data[STAGES-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid[0] <= fire;
            for (int i = 1; i < STAGES; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stage_rd[0]   <= mul_if.packet.rd;
            stage_data[0] <= product[`CORE_XLEN-1:0];
            for (int i = 1; i < STAGES; i++) begin
                stage_rd[i]   <= stage_rd[i-1];
                stage_data[i] <= stage_data[i-1];
            end
        end
    end

endmodule

//--- writeback_arbiter.sv
/*
 * Writeback arbiter
 * Fixed priority (multiplier first), combinational
 * writeback packet plus a registered trace copy
 */
`include "core_defines.svh"

module writeback_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    exec_unit_if.wb              alu_if,
    exec_unit_if.wb              mul_if,
    output core_pkg::wb_packet_t wb,
    output core_pkg::wb_packet_t trace
);

    core_pkg::unit_t winner;

    assign winner = mul_if.done ? core_pkg::UNIT_MUL : core_pkg::UNIT_ALU;

    assign mul_if.ack = mul_if.done;
    assign alu_if.ack = alu_if.done && (winner == core_pkg::UNIT_ALU);

    always_comb begin
        wb.valid = mul_if.done || alu_if.done;
        if (winner == core_pkg::UNIT_MUL) begin
            wb.rd   = mul_if.result_rd;
            wb.data = mul_if.result_data;
        end else begin
            wb.rd   = alu_if.result_rd;
            wb.data = alu_if.result_data;
        end
    end

    // Trace shows each write one cycle after it lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trace <= '0;
        end else begin
            trace <= wb;
        end
    end

    // A losing ALU result waits unchanged for its ack
    assert property (@(posedge clk) disable iff (!rst_n)
        alu_if.done && !alu_if.ack |=>
            alu_if.done && $stable(alu_if.result_rd) && $stable(alu_if.result_data));

endmodule

//--- core_top.sv
/*
 * Core top level
 * Fetch, decode/issue, register file, ALU, multiplier
 * and writeback arbiter behind plain ports
 */
`include "core_defines.svh"

module core_top (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic                        ibus_cyc,
    output logic                        ibus_stb,
    output logic [`CORE_XLEN-1:0]       ibus_adr,
    input  logic [`CORE_XLEN-1:0]       ibus_dat_r,
    input  logic                        ibus_ack,
    output logic                        wb_valid,
    output logic [`CORE_REG_ADDR_W-1:0] wb_rd,
    output logic [`CORE_XLEN-1:0]       wb_data
);

    logic                        instr_valid;
    logic [`CORE_XLEN-1:0]       instr;
    logic                        instr_ready;
    logic [`CORE_REG_ADDR_W-1:0] rs1_addr;
    logic [`CORE_REG_ADDR_W-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]       rs1_data;
    logic [`CORE_XLEN-1:0]       rs2_data;
    core_pkg::wb_packet_t        wb;
    core_pkg::wb_packet_t        trace;

    exec_unit_if alu_if ();
    exec_unit_if mul_if ();

    //////////////////////////////////////////////////
    // Front end
    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .ibus_cyc    (ibus_cyc),
        .ibus_stb    (ibus_stb),
        .ibus_adr    (ibus_adr),
        .ibus_dat_r  (ibus_dat_r),
        .ibus_ack    (ibus_ack),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready)
    );

    decode_issue u_decode_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb          (wb),
        .alu_if      (alu_if),
        .mul_if      (mul_if)
    );

    register_file u_register_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    //////////////////////////////////////////////////
    // Execution and writeback
    alu_unit u_alu_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .alu_if (alu_if)
    );

    mul_unit u_mul_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .mul_if (mul_if)
    );

    writeback_arbiter u_writeback_arbiter (
        .clk    (clk),
        .rst_n  (rst_n),
        .alu_if (alu_if),
        .mul_if (mul_if),
        .wb     (wb),
        .trace  (trace)
    );

    assign wb_valid = trace.valid;
    assign wb_rd    = trace.rd;
    assign wb_data  = trace.data;

endmodule

//--- tb_checker.sv
/*
 * Writeback checker
 * Follows fetched instructions through a reference model and
 * matches every trace write against its expected value
 */
`include "core_defines.svh"

module tb_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ibus_cyc,
    input  logic                        ibus_stb,
    input  logic                        ibus_ack,
    input  logic [`CORE_XLEN-1:0]       ibus_adr,
    input  logic [`CORE_XLEN-1:0]       ibus_dat_r,
    input  logic                        wb_valid,
    input  logic [`CORE_REG_ADDR_W-1:0] wb_rd,
    input  logic [`CORE_XLEN-1:0]       wb_data,
    input  int                          test_id,
    input  logic                        test_end,
    output int                          pending,
    output int                          errors,
    output int                          checked
);

    timeunit 1ns;
    timeprecision 1ps;

    // Architectural state with x0 held at zero
    logic [31:0][31:0] model = '0;
    logic [4:0]        exp_rd  [$];
    logic [31:0]       exp_val [$];
    logic [31:0]       next_adr = `CORE_RESET_PC;
    int                err_count = 0;
    int                chk_count = 0;
    int                pend_count = 0;
    int                test_checked = 0;
    int                test_errors = 0;

    assign pending = pend_count;
    assign errors  = err_count;
    assign checked = chk_count;

    //////////////////////////////////////////////////
    // RV32I OP, OP-IMM and MUL reference
    function automatic void run_reference(
        input  logic [31:0]       ins,
        input  logic [31:0][31:0] regs,
        output logic [4:0]        rd,
        output logic [31:0]       value
    );
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] sa;
        logic [4:0]         shamt;
        logic signed [63:0] product;
        logic               is_op;
        logic               is_imm;
        logic               alt;
        is_op   = (ins[6:0] == 7'b0110011);
        is_imm  = (ins[6:0] == 7'b0010011);
        rd      = ins[11:7];
        a       = regs[ins[19:15]];
        b       = is_op ? regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        sa      = a;
        shamt   = b[4:0];
        alt     = ins[30];
        product = $signed(a) * $signed(b);
        value   = '0;
        if (!is_op && !is_imm) begin
            // Unknown opcode retires as a no-op
            rd = 5'd0;
        end else if (is_op && ins[31:25] == 7'h01) begin
            value = product[31:0];
        end else begin
            case (ins[14:12])
                3'd0:    value = (is_op && alt) ? a - b : a + b;
                3'd1:    value = a << shamt;
                3'd2:    value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3:    value = (a < b) ? 32'd1 : 32'd0;
                3'd4:    value = a ^ b;
                3'd5: begin
                    if (alt) begin
                        value = sa >>> shamt;
                    end else begin
                        value = a >> shamt;
                    end
                end
                3'd6:    value = a | b;
                default: value = a & b;
            endcase
        end
    endfunction

    task automatic count_error();
        err_count++;
        test_errors++;
    endtask

    //////////////////////////////////////////////////
    // Fetch tracking and writeback matching
    always @(posedge clk) begin : watch
        logic [4:0]  rd;
        logic [31:0] value;
        int          idx;
        if (!rst_n) begin
            next_adr = `CORE_RESET_PC;
            if (ibus_cyc || ibus_stb || wb_valid) begin
                $display("bus request or writeback seen while reset is held, at %0t", $time);
                count_error();
            end
        end else begin
            if (ibus_stb !== ibus_cyc) begin
                $display("error at %0t: ibus_stb %b with ibus_cyc %b",
                         $time, ibus_stb, ibus_cyc);
                count_error();
            end

            if (ibus_cyc && ibus_ack) begin
                if (ibus_adr !== next_adr) begin
                    $display("error at %0t: fetch from %h, expected %h",
                             $time, ibus_adr, next_adr);
                    count_error();
                end
                next_adr = ibus_adr + 32'd4;
                run_reference(ibus_dat_r, model, rd, value);
                if (rd != 5'd0) begin
                    model[rd] = value;
                    exp_rd.push_back(rd);
                    exp_val.push_back(value);
                end
            end

            if (wb_valid) begin
                // Oldest expectation with the same rd
                idx = -1;
                for (int i = 0; i < exp_rd.size(); i++) begin
                    if (idx < 0 && exp_rd[i] == wb_rd) begin
                        idx = i;
                    end
                end
                if (idx < 0) begin
                    $display("writeback to x%0d at %0t with no instruction waiting for it",
                             wb_rd, $time);
                    count_error();
                end else begin
                    if (wb_data !== exp_val[idx]) begin
                        $display("error at %0t: x%0d written with %h, expected %h",
                                 $time, wb_rd, wb_data, exp_val[idx]);
                        count_error();
                    end
                    exp_rd.delete(idx);
                    exp_val.delete(idx);
                    test_checked++;
                end
            end

            if (test_end) begin
                if (exp_rd.size() != 0) begin
                    $display("test %0d ended with %0d writebacks never seen",
                             test_id, exp_rd.size());
                    count_error();
                    exp_rd.delete();
                    exp_val.delete();
                end
                $display("test %0d %s: %0d writebacks checked, %0d errors", test_id,
                         (test_errors == 0) ? "passed" : "failed", test_checked, test_errors);
                chk_count    = chk_count + test_checked;
                test_checked = 0;
                test_errors  = 0;
            end
        end
        pend_count = exp_rd.size();
    end

endmodule

//--- tb_core.sv
/*
 * Core testbench
 * Clock, reset, Wishbone instruction memory with random
 * wait states, random program generator and watchdog
 */
`include "core_defines.svh"

module tb_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_TESTS    = 6;
    localparam int          MAX_LEN      = 64;
    localparam int          RESET_CYCLES = 5;
    localparam int          DRAIN_CYCLES = 10;
    localparam int          MAX_WAIT     = 3;
    localparam int          SEED         = 41;
    localparam logic [31:0] NOP          = 32'h0000_0013;
    // reg init, ALU mix, MUL only, dependent chain, MUL/ALU interleave, x0 rules
    localparam int          TEST_LEN [NUM_TESTS] = '{31, 60, 40, 50, 60, 40};

    logic                        clk = 1'b0;
    logic                        rst_n = 1'b0;
    logic                        ibus_cyc;
    logic                        ibus_stb;
    logic [`CORE_XLEN-1:0]       ibus_adr;
    logic [`CORE_XLEN-1:0]       ibus_dat_r;
    logic                        ibus_ack;
    logic                        wb_valid;
    logic [`CORE_REG_ADDR_W-1:0] wb_rd;
    logic [`CORE_XLEN-1:0]       wb_data;

    logic [31:0] prog     [MAX_LEN];
    int          wait_tab [MAX_LEN];
    int          prog_len;
    int          waited;
    int          test_id;
    logic        test_end;
    int          pending;
    int          errors;
    int          checked;

    always #2 clk = ~clk;

    core_top u_core_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_adr   (ibus_adr),
        .ibus_dat_r (ibus_dat_r),
        .ibus_ack   (ibus_ack),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    tb_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_ack   (ibus_ack),
        .ibus_adr   (ibus_adr),
        .ibus_dat_r (ibus_dat_r),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .test_id    (test_id),
        .test_end   (test_end),
        .pending    (pending),
        .errors     (errors),
        .checked    (checked)
    );

    //////////////////////////////////////////////////
    // Instruction encoding and program generation
    function automatic logic [31:0] encode_op(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_op_imm(input logic [11:0] imm, input logic [4:0] rs1,
                                                  input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] random_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        f3  = 3'($urandom_range(7, 0));
        alt = 1'($urandom_range(1, 0));
        imm = 12'($urandom);
        if ($urandom_range(1, 0) == 0) begin
            // SUB and SRA set funct7 bit 5
            return encode_op((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                             rs2, rs1, f3, rd);
        end
        if (f3 == 3'd1) begin
            imm[11:5] = 7'h00;
        end else if (f3 == 3'd5) begin
            imm[11:5] = alt ? 7'h20 : 7'h00;
        end
        return encode_op_imm(imm, rs1, f3, rd);
    endfunction

    function automatic logic [31:0] mul_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        return encode_op(7'h01, rs2, rs1, 3'd0, rd);
    endfunction

    function automatic logic [4:0] any_reg();
        return 5'($urandom_range(31, 0));
    endfunction

    task automatic build_program(input int t);
        logic [4:0] rd;
        logic [4:0] prev_rd;
        prev_rd  = 5'd1;
        prog_len = TEST_LEN[t];
        for (int i = 0; i < MAX_LEN; i++) begin
            wait_tab[i] = $urandom_range(MAX_WAIT, 0);
        end
        for (int i = 0; i < prog_len; i++) begin
            rd = 5'($urandom_range(31, 1));
            case (t)
                0: prog[i] = encode_op_imm(12'($urandom), 5'd0, 3'd0, 5'(i + 1));
                1: prog[i] = random_alu(rd, any_reg(), any_reg());
                2: prog[i] = mul_instr(rd, any_reg(), any_reg());
                3: prog[i] = ($urandom_range(1, 0) == 0) ? mul_instr(rd, prev_rd, any_reg())
                                                         : random_alu(rd, prev_rd, any_reg());
                4: begin
                    // MUL and ALU alternating with a fresh rd each time
                    rd      = 5'(i % 31 + 1);
                    prog[i] = (i % 2 == 0) ? mul_instr(rd, any_reg(), any_reg())
                                           : random_alu(rd, any_reg(), any_reg());
                end
                default: begin
                    if (i % 2 == 0) begin
                        prog[i] = (i % 4 == 0) ? mul_instr(5'd0, any_reg(), any_reg())
                                               : random_alu(5'd0, any_reg(), any_reg());
                    end else begin
                        prog[i] = (i % 4 == 1) ? random_alu(rd, 5'd0, 5'd0)
                                               : mul_instr(rd, any_reg(), 5'd0);
                    end
                end
            endcase
            prev_rd = rd;
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] adr);
        int idx;
        idx = int'(adr >> 2);
        if (idx < prog_len) begin
            return prog[idx];
        end
        return NOP;
    endfunction

    //////////////////////////////////////////////////
    // Wishbone slave with wait states fixed per word
    always @(negedge clk) begin
        if (!rst_n) begin
            ibus_ack = 1'b0;
            waited   = 0;
        end else if (ibus_ack) begin
            ibus_ack = 1'b0;
        end else if (ibus_cyc && ibus_stb) begin
            if (waited >= wait_tab[int'(ibus_adr >> 2) % MAX_LEN]) begin
                ibus_ack   = 1'b1;
                ibus_dat_r = fetch_word(ibus_adr);
                waited     = 0;
            end else begin
                waited++;
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        ibus_ack   = 1'b0;
        ibus_dat_r = '0;
        test_id    = 0;
        test_end   = 1'b0;
        prog_len   = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            rst_n   = 1'b0;
            test_id = t;
            build_program(t);
            repeat (RESET_CYCLES) @(negedge clk);
            rst_n = 1'b1;
            // Whole program fetched, then all expected writebacks seen
            while (ibus_adr < 32'(prog_len * 4) || pending != 0) begin
                @(negedge clk);
            end
            repeat (DRAIN_CYCLES) @(negedge clk);
            test_end = 1'b1;
            @(negedge clk);
            test_end = 1'b0;
        end
        @(negedge clk);
        $display("tests %0d, writebacks checked %0d, errors %0d", NUM_TESTS, checked, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog budget of 40 cycles per instruction plus reset and drain
    initial begin : watchdog
        int budget;
        budget = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            budget += 40 * TEST_LEN[t] + RESET_CYCLES + DRAIN_CYCLES + 4;
        end
        repeat (budget) @(posedge clk);
        $display("timeout: test %0d did not finish, %0d writebacks still missing",
                 test_id, pending);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
core_pkg.sv
exec_unit_if.sv
fetch_unit.sv
decode_issue.sv
register_file.sv
alu_unit.sv
mul_unit.sv
writeback_arbiter.sv
core_top.sv
tb_checker.sv
tb_core.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_core -f filelist.f -o sim_core
./obj_dir/sim_core > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
